// File: rtl/rv32i_pkg.sv
//######################################################################
// RV32I base integer types shared by the core and its sub-blocks
// opcode values are ir[6:2], the low 2'b11 of every instruction is
// checked by decode and otherwise dropped
//######################################################################
package rv32i_pkg;

  typedef logic [31:0] word_t;  // data or byte address
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;

  typedef enum logic [4:0] {
    OpcLoad   = 5'b00000,
    OpcOpImm  = 5'b00100,
    OpcAuipc  = 5'b00101,
    OpcStore  = 5'b01000,
    OpcOp     = 5'b01100,
    OpcLui    = 5'b01101,
    OpcBranch = 5'b11000,
    OpcJalr   = 5'b11001,
    OpcJal    = 5'b11011
  } opcode_e;

  // funct3 of OP and OP_IMM
  typedef enum funct3_t {
    AluAdd  = 3'b000,
    AluSll  = 3'b001,
    AluSlt  = 3'b010,
    AluSltu = 3'b011,
    AluXor  = 3'b100,
    AluSr   = 3'b101,  // srl or sra by bit 30
    AluOr   = 3'b110,
    AluAnd  = 3'b111
  } alu_f3_e;

  // funct3 of BRANCH
  typedef enum funct3_t {
    BrEq  = 3'b000,
    BrNe  = 3'b001,
    BrLt  = 3'b100,
    BrGe  = 3'b101,
    BrLtu = 3'b110,
    BrGeu = 3'b111
  } branch_f3_e;

  typedef struct packed {
    opcode_e  opcode;
    funct3_t  funct3;
    logic     alt;      // ir[30], sub and sra
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;      // already sign extended
    logic     illegal;
  } decoded_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
    word_t    pc;
  } retire_t;

endpackage

// File: rtl/ramio_pkg.sv
//######################################################################
// memory port types between core and ramio
// read type: 0 no read, bit 2 sign extend, low bits 01 byte 10 half 11 word
// the load port carries a word address, not a byte address
//######################################################################
package ramio_pkg;

  typedef logic [2:0] read_type_t;
  typedef logic [1:0] write_type_t;

  localparam read_type_t ReadNone = 3'b000;
  localparam read_type_t ReadWord = 3'b111;

  localparam write_type_t WriteNone = 2'b00;
  localparam write_type_t WriteByte = 2'b01;
  localparam write_type_t WriteHalf = 2'b10;
  localparam write_type_t WriteWord = 2'b11;

  typedef struct packed {
    logic             enable;
    read_type_t       read_type;
    write_type_t      write_type;
    rv32i_pkg::word_t address;  // byte address
    rv32i_pkg::word_t data_in;  // unshifted, lane chosen by ramio
  } ram_req_t;

  typedef struct packed {
    rv32i_pkg::word_t address;  // word index
    rv32i_pkg::word_t data;
  } load_t;

endpackage

// File: rtl/decode.sv
//######################################################################
// instruction field split and immediate selection, purely combinational
// FENCE, SYSTEM and any funct3 the core cannot run are flagged illegal
//######################################################################
module decode (
  input  rv32i_pkg::word_t    ir,
  output rv32i_pkg::decoded_t dec
);

  rv32i_pkg::opcode_e opcode;
  rv32i_pkg::funct3_t funct3;
  logic known;  // opcode and funct3 pair supported

  assign opcode = rv32i_pkg::opcode_e'(ir[6:2]);
  assign funct3 = ir[14:12];

  always_comb begin
    known = 1'b1;
    dec.imm = '0;
    case (opcode)
      rv32i_pkg::OpcLui, rv32i_pkg::OpcAuipc: begin
        dec.imm = {ir[31:12], 12'b0};  // U
      end
      rv32i_pkg::OpcJal: begin
        dec.imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};  // J
      end
      rv32i_pkg::OpcJalr: begin
        dec.imm = {{21{ir[31]}}, ir[30:20]};
        known = funct3 == 3'b000;
      end
      rv32i_pkg::OpcBranch: begin
        dec.imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};  // B
        known = funct3[2:1] != 2'b01;  // 010 and 011 unused
      end
      rv32i_pkg::OpcLoad: begin
        dec.imm = {{21{ir[31]}}, ir[30:20]};
        known = funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11;  // lb lh lw lbu lhu
      end
      rv32i_pkg::OpcStore: begin
        dec.imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};  // S
        known = funct3 < 3'd3;
      end
      rv32i_pkg::OpcOpImm: begin
        dec.imm = {{21{ir[31]}}, ir[30:20]};  // shamt sits in imm[4:0]
      end
      rv32i_pkg::OpcOp: begin
        known = 1'b1;  // register operands only
      end
      default: known = 1'b0;
    endcase
    dec.opcode = opcode;
    dec.funct3 = funct3;
    dec.alt = ir[30];
    dec.rs1 = ir[19:15];
    dec.rs2 = ir[24:20];
    dec.rd = ir[11:7];
    dec.illegal = !known || ir[1:0] != 2'b11;
  end

endmodule

// File: rtl/execute.sv
//######################################################################
// ALU, branch compare and next pc for the instruction held in ir
// jalr clears bit 0 of its target, misaligned targets are not trapped
//######################################################################
module execute (
  input  rv32i_pkg::decoded_t dec,
  input  rv32i_pkg::word_t    pc,
  input  rv32i_pkg::word_t    rs1_data,
  input  rv32i_pkg::word_t    rs2_data,
  output rv32i_pkg::word_t    alu_result,
  output rv32i_pkg::word_t    link,
  output logic                branch_taken,
  output rv32i_pkg::word_t    next_pc,
  output rv32i_pkg::word_t    mem_address
);

  rv32i_pkg::word_t operand_b;
  rv32i_pkg::word_t alu_out;
  rv32i_pkg::word_t target;  // pc relative jump or branch
  logic [4:0] shamt;
  logic equal;
  logic signed_lt;
  logic unsigned_lt;
  logic condition;

  // branches compare rs1 with rs2 through the same path as slt
  assign operand_b = (dec.opcode == rv32i_pkg::OpcOp || dec.opcode == rv32i_pkg::OpcBranch)
                     ? rs2_data : dec.imm;
  assign shamt = operand_b[4:0];
  assign equal = rs1_data == operand_b;
  assign signed_lt = $signed(rs1_data) < $signed(operand_b);
  assign unsigned_lt = rs1_data < operand_b;

  assign target = pc + dec.imm;
  assign link = pc + 32'd4;
  assign mem_address = rs1_data + dec.imm;  // also the jalr target

  always_comb begin
    case (rv32i_pkg::alu_f3_e'(dec.funct3))
      rv32i_pkg::AluAdd: begin
        if (dec.opcode == rv32i_pkg::OpcOp && dec.alt) begin
          alu_out = rs1_data - operand_b;
        end else begin
          alu_out = rs1_data + operand_b;
        end
      end
      rv32i_pkg::AluSll:  alu_out = rs1_data << shamt;
      rv32i_pkg::AluSlt:  alu_out = {31'b0, signed_lt};
      rv32i_pkg::AluSltu: alu_out = {31'b0, unsigned_lt};
      rv32i_pkg::AluXor:  alu_out = rs1_data ^ operand_b;
      rv32i_pkg::AluSr: begin
        if (dec.alt) begin
          alu_out = $signed(rs1_data) >>> shamt;
        end else begin
          alu_out = rs1_data >> shamt;
        end
      end
      rv32i_pkg::AluOr:   alu_out = rs1_data | operand_b;
      default:            alu_out = rs1_data & operand_b;
    endcase
  end

  always_comb begin
    case (rv32i_pkg::branch_f3_e'(dec.funct3))
      rv32i_pkg::BrEq:  condition = equal;
      rv32i_pkg::BrNe:  condition = !equal;
      rv32i_pkg::BrLt:  condition = signed_lt;
      rv32i_pkg::BrGe:  condition = !signed_lt;
      rv32i_pkg::BrLtu: condition = unsigned_lt;
      rv32i_pkg::BrGeu: condition = !unsigned_lt;
      default:          condition = 1'b0;
    endcase
  end

  assign branch_taken = dec.opcode == rv32i_pkg::OpcBranch && condition;

  always_comb begin
    case (dec.opcode)
      rv32i_pkg::OpcLui:   alu_result = dec.imm;
      rv32i_pkg::OpcAuipc: alu_result = target;
      default:             alu_result = alu_out;
    endcase
  end

  always_comb begin
    if (dec.opcode == rv32i_pkg::OpcJal || branch_taken) begin
      next_pc = target;
    end else if (dec.opcode == rv32i_pkg::OpcJalr) begin
      next_pc = {mem_address[31:1], 1'b0};
    end else begin
      next_pc = link;
    end
  end

endmodule

// File: rtl/writeback.sv
//######################################################################
// register write value: load data, link or ALU result
// load_word is the raw aligned RAM word, address_low picks the lane
//######################################################################
module writeback (
  input  rv32i_pkg::decoded_t dec,
  input  rv32i_pkg::word_t    alu_result,
  input  rv32i_pkg::word_t    link,
  input  rv32i_pkg::word_t    load_word,
  input  logic [1:0]          address_low,
  output rv32i_pkg::word_t    rd_data
);

  rv32i_pkg::word_t shifted;
  rv32i_pkg::word_t load_value;
  logic sign;

  assign shifted = load_word >> {address_low, 3'b000};

  always_comb begin
    case (dec.funct3[1:0])
      2'b00: begin
        sign = shifted[7] & ~dec.funct3[2];  // lbu zero extends
        load_value = {{24{sign}}, shifted[7:0]};
      end
      2'b01: begin
        sign = shifted[15] & ~dec.funct3[2];
        load_value = {{16{sign}}, shifted[15:0]};
      end
      default: begin
        sign = 1'b0;
        load_value = shifted;
      end
    endcase
  end

  always_comb begin
    case (dec.opcode)
      rv32i_pkg::OpcLoad:                    rd_data = load_value;
      rv32i_pkg::OpcJal, rv32i_pkg::OpcJalr: rd_data = link;
      default:                               rd_data = alu_result;
    endcase
  end

endmodule

// File: rtl/registers.sv
//######################################################################
// 32 x 32 register file, two asynchronous reads and one write port
// contents are undefined after reset, x0 always reads zero
//######################################################################
module registers (
  input  logic                clk,
  input  rv32i_pkg::reg_idx_t rs1,
  output rv32i_pkg::word_t    rs1_data,
  input  rv32i_pkg::reg_idx_t rs2,
  output rv32i_pkg::word_t    rs2_data,
  input  rv32i_pkg::reg_idx_t rd,
  input  logic                rd_write_enable,
  input  rv32i_pkg::word_t    rd_data
);

  rv32i_pkg::word_t regs [32];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rd_write_enable) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// File: rtl/ramio.sv
//######################################################################
// word RAM with byte lane writes, RamWords a power of two, at least 2
// reads return the whole aligned word one cycle later
// busy is high for the one cycle after each write, load wins over req
//######################################################################
module ramio #(
  parameter int unsigned RamWords = 256
) (
  input  logic               clk,
  input  logic               rst_n,
  input  ramio_pkg::ram_req_t req,
  output rv32i_pkg::word_t   data_out,
  output logic               data_out_ready,
  output logic               busy,
  input  logic               load_valid,
  input  ramio_pkg::load_t   load
);

  localparam int unsigned IndexBits = $clog2(RamWords);

  rv32i_pkg::word_t mem [RamWords];
  logic [IndexBits-1:0] index;
  logic [3:0] byte_enable;
  rv32i_pkg::word_t write_data;
  logic do_read;
  logic do_write;

  assign index = req.address[IndexBits+1:2];  // upper address bits wrap
  assign do_read = req.enable && req.read_type != ramio_pkg::ReadNone;
  assign do_write = req.enable && req.write_type != ramio_pkg::WriteNone;
  assign write_data = req.data_in << {req.address[1:0], 3'b000};

  always_comb begin
    case (req.write_type)
      ramio_pkg::WriteByte: byte_enable = 4'b0001 << req.address[1:0];
      ramio_pkg::WriteHalf: byte_enable = req.address[1] ? 4'b1100 : 4'b0011;
      ramio_pkg::WriteWord: byte_enable = 4'b1111;
      default:              byte_enable = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (load_valid) begin
      mem[load.address[IndexBits-1:0]] <= load.data;
    end else if (do_write) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_enable[i]) begin
          mem[index][8*i +: 8] <= write_data[8*i +: 8];
        end
      end
    end
    if (do_read) begin
      data_out <= mem[index];  // raw word, writeback aligns
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out_ready <= 1'b0;
      busy <= 1'b0;
    end else begin
      data_out_ready <= do_read;
      busy <= do_write;
    end
  end

endmodule

// File: rtl/core.sv
//######################################################################
// multi-cycle RV32I controller, one instruction in flight
// every memory request is a one-cycle pulse on ram_req.enable
// an illegal instruction sets fault and halts the core until reset
//######################################################################
module core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output ramio_pkg::ram_req_t ram_req,
  input  rv32i_pkg::word_t    ram_data_out,
  input  logic                ram_data_ready,
  input  logic                ram_busy,
  output rv32i_pkg::reg_idx_t rs1,
  output rv32i_pkg::reg_idx_t rs2,
  input  rv32i_pkg::word_t    rs1_data,
  input  rv32i_pkg::word_t    rs2_data,
  output logic                rd_write_enable,
  output rv32i_pkg::reg_idx_t rd,
  output rv32i_pkg::word_t    rd_data,
  output logic                retire_valid,
  output rv32i_pkg::retire_t  retire,
  output logic                fault
);

  typedef enum logic [2:0] {
    Idle,
    Fetch,
    Execute,
    Store,
    Load,
    Halt
  } state_e;

  state_e state;
  rv32i_pkg::word_t pc;  // pc of the instruction in ir
  rv32i_pkg::word_t ir;
  rv32i_pkg::decoded_t dec;
  rv32i_pkg::word_t alu_result;
  rv32i_pkg::word_t link;
  rv32i_pkg::word_t next_pc;
  rv32i_pkg::word_t mem_address;
  logic writes_rd;

  function automatic ramio_pkg::ram_req_t fetch_req(rv32i_pkg::word_t address);
    fetch_req = '{
      enable: 1'b1,
      read_type: ramio_pkg::ReadWord,
      write_type: ramio_pkg::WriteNone,
      address: address,
      data_in: '0
    };
  endfunction

  decode decode_i (
    .ir,
    .dec
  );

  execute execute_i (
    .dec,
    .pc,
    .rs1_data,
    .rs2_data,
    .alu_result,
    .link,
    .branch_taken(),  // already folded into next_pc
    .next_pc,
    .mem_address
  );

  writeback writeback_i (
    .dec,
    .alu_result,
    .link,
    .load_word(ram_data_out),
    .address_low(ram_req.address[1:0]),  // address is held after the pulse
    .rd_data
  );

  assign rs1 = dec.rs1;
  assign rs2 = dec.rs2;
  assign rd = dec.rd;

  always_comb begin
    case (dec.opcode)
      rv32i_pkg::OpcLui, rv32i_pkg::OpcAuipc, rv32i_pkg::OpcJal,
      rv32i_pkg::OpcJalr, rv32i_pkg::OpcOpImm, rv32i_pkg::OpcOp: begin
        writes_rd = state == Execute && !dec.illegal;
      end
      rv32i_pkg::OpcLoad: writes_rd = state == Load && ram_data_ready;
      default:            writes_rd = 1'b0;
    endcase
  end

  assign rd_write_enable = writes_rd && rd != '0;
  assign retire_valid = rd_write_enable;
  assign retire = '{rd: rd, data: rd_data, pc: pc};

  always_ff @(posedge clk) begin
    if (state == Fetch && ram_data_ready) begin
      ir <= ram_data_out;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
      pc <= '0;
      ram_req <= '0;
      fault <= 1'b0;
    end else begin
      unique case (state)
        Idle: begin
          if (start) begin
            ram_req <= fetch_req(pc);  // pc is 0 out of reset
            state <= Fetch;
          end
        end
        Fetch: begin
          ram_req.enable <= 1'b0;
          if (ram_data_ready) begin
            state <= Execute;
          end
        end
        Execute: begin
          if (dec.illegal) begin
            fault <= 1'b1;  // sticky until reset
            state <= Halt;
          end else if (dec.opcode == rv32i_pkg::OpcStore) begin
            ram_req <= '{
              enable: 1'b1,
              read_type: ramio_pkg::ReadNone,
              write_type: ramio_pkg::write_type_t'(dec.funct3[1:0] + 2'd1),
              address: mem_address,
              data_in: rs2_data
            };
            state <= Store;
          end else if (dec.opcode == rv32i_pkg::OpcLoad) begin
            ram_req <= '{
              enable: 1'b1,
              read_type: ramio_pkg::read_type_t'({~dec.funct3[2], dec.funct3[1:0] + 2'd1}),
              write_type: ramio_pkg::WriteNone,
              address: mem_address,
              data_in: '0
            };
            state <= Load;
          end else begin
            pc <= next_pc;
            ram_req <= fetch_req(next_pc);
            state <= Fetch;
          end
        end
        Store: begin
          ram_req.enable <= 1'b0;
          // busy means the write landed, it is low again when the fetch is seen
          if (!ram_req.enable && ram_busy) begin
            pc <= next_pc;
            ram_req <= fetch_req(next_pc);
            state <= Fetch;
          end
        end
        Load: begin
          ram_req.enable <= 1'b0;
          if (ram_data_ready) begin  // rd written this cycle
            pc <= next_pc;
            ram_req <= fetch_req(next_pc);
            state <= Fetch;
          end
        end
        Halt: begin
          ram_req.enable <= 1'b0;
        end
        default: begin
          fault <= 1'b1;
          state <= Halt;
        end
      endcase
    end
  end

endmodule

// File: rtl/soc_top.sv
//######################################################################
// core, register file and RAM of the RV32I subsystem
// load the program through load/load_valid while idle, then pulse start
// retire reports every register write except to x0
//######################################################################
module soc_top #(
  parameter int unsigned RamWords = 256
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_valid,
  input  ramio_pkg::load_t   load,
  input  logic               start,
  output logic               retire_valid,
  output rv32i_pkg::retire_t retire,
  output logic               fault
);

  ramio_pkg::ram_req_t ram_req;
  rv32i_pkg::word_t ram_data_out;
  logic ram_data_ready;
  logic ram_busy;
  rv32i_pkg::reg_idx_t rs1;
  rv32i_pkg::reg_idx_t rs2;
  rv32i_pkg::reg_idx_t rd;
  rv32i_pkg::word_t rs1_data;
  rv32i_pkg::word_t rs2_data;
  rv32i_pkg::word_t rd_data;
  logic rd_write_enable;

  core core_i (
    .clk,
    .rst_n,
    .start,
    .ram_req,
    .ram_data_out,
    .ram_data_ready,
    .ram_busy,
    .rs1,
    .rs2,
    .rs1_data,
    .rs2_data,
    .rd_write_enable,
    .rd,
    .rd_data,
    .retire_valid,
    .retire,
    .fault
  );

  registers registers_i (
    .clk,
    .rs1,
    .rs1_data,
    .rs2,
    .rs2_data,
    .rd,
    .rd_write_enable,
    .rd_data
  );

  ramio #(
    .RamWords(RamWords)
  ) ramio_i (
    .clk,
    .rst_n,
    .req(ram_req),
    .data_out(ram_data_out),
    .data_out_ready(ram_data_ready),
    .busy(ram_busy),
    .load_valid,
    .load
  );

endmodule

// File: bench/soc_assertions.sv
//######################################################################
// memory port and retire checks, bound into every core instance
// reports only through failing assertions, inactive while rst_n is low
//######################################################################
module soc_assertions (
  input logic                clk,
  input logic                rst_n,
  input ramio_pkg::ram_req_t ram_req,
  input logic                ram_data_ready,
  input logic                ram_busy,
  input logic                retire_valid,
  input rv32i_pkg::retire_t  retire,
  input logic                fault
);

  logic read_req;

  assign read_req = ram_req.enable && ram_req.read_type != ramio_pkg::ReadNone;

  no_request_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) ram_busy |-> !ram_req.enable
  ) else $error("memory request issued while ramio is busy");

  ready_follows_read: assert property (
    @(posedge clk) disable iff (!rst_n) ram_data_ready |-> $past(read_req)
  ) else $error("data_out_ready without a read request one cycle before");

  read_gets_ready: assert property (
    @(posedge clk) disable iff (!rst_n) read_req |=> ram_data_ready
  ) else $error("read request not answered one cycle later");

  retire_not_x0: assert property (
    @(posedge clk) disable iff (!rst_n) retire_valid |-> retire.rd != '0
  ) else $error("retire reported a write to x0");

  fault_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) fault |=> fault
  ) else $error("fault dropped before reset");

endmodule

bind core soc_assertions soc_assertions_i (
  .clk,
  .rst_n,
  .ram_req,
  .ram_data_ready,
  .ram_busy,
  .retire_valid,
  .retire,
  .fault
);

// File: bench/tb_soc.sv
//######################################################################
// testbench for soc_top, loads an RV32I program through the load port,
// pulses start and checks every retire against a small ISA model
// stops at the first error, program image must stay below byte 0x200
//######################################################################
module tb_soc;

  localparam int RamWords = 256;
  localparam int ResetCycles = 16;
  localparam int DataBase = 32'h200;  // store and load area

  logic clk;
  logic rst_n;
  logic load_valid;
  ramio_pkg::load_t load;
  logic start;
  logic retire_valid;
  rv32i_pkg::retire_t retire;
  logic fault;

  rv32i_pkg::word_t prog [RamWords];  // program image by word index
  rv32i_pkg::retire_t expected [$];   // retire sequence in order
  rv32i_pkg::word_t xr [32];          // model register file
  logic [7:0] data_bytes [1024];      // model of the low RAM bytes
  rv32i_pkg::word_t at_pc;            // layout and model pc
  int prog_len;
  int seed;
  logic failed;
  logic built;

  soc_top #(
    .RamWords(RamWords)
  ) dut_i (
    .clk,
    .rst_n,
    .load_valid,
    .load,
    .start,
    .retire_valid,
    .retire,
    .fault
  );

  always #10 clk = ~clk;

  task automatic stop_run();
    failed = 1'b1;
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_failure(input string why);
    $display("Error at time %0t: %s", $time, why);
    stop_run();
  endtask

  task automatic check_value(input string name, input rv32i_pkg::word_t got,
                             input rv32i_pkg::word_t want);
    if (got !== want) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;  // inputs change clear of the edge
  endtask

  task automatic wait_retire();
    @(negedge clk);
    while (!retire_valid) begin
      if (fault) begin
        report_failure("fault raised while retires were still expected");
      end else begin
        @(negedge clk);
      end
    end
  endtask

  function automatic rv32i_pkg::word_t alu_ref(input logic [2:0] f3, input logic sub_or_sra,
                                               input rv32i_pkg::word_t a,
                                               input rv32i_pkg::word_t b);
    case (f3)
      3'd0: alu_ref = sub_or_sra ? a - b : a + b;
      3'd1: alu_ref = a << b[4:0];
      3'd2: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: alu_ref = (a < b) ? 32'd1 : 32'd0;
      3'd4: alu_ref = a ^ b;
      3'd5: begin
        if (sub_or_sra) begin
          alu_ref = $signed(a) >>> b[4:0];
        end else begin
          alu_ref = a >> b[4:0];
        end
      end
      3'd6: alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  task automatic emit_word(input rv32i_pkg::word_t instr);
    prog[at_pc >> 2] = instr;
    prog_len = int'(at_pc >> 2) + 1;  // layout only moves forward
  endtask

  task automatic note_write(input rv32i_pkg::reg_idx_t rd, input rv32i_pkg::word_t value);
    rv32i_pkg::retire_t entry;
    if (rd != '0) begin
      xr[rd] = value;
      entry.rd = rd;
      entry.data = value;
      entry.pc = at_pc;
      expected.push_back(entry);
    end
  endtask

  task automatic reg_op(input logic [2:0] f3, input logic alt,
                        input rv32i_pkg::reg_idx_t rd, rs1, rs2);
    emit_word({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011});
    note_write(rd, alu_ref(f3, alt, xr[rs1], xr[rs2]));
    at_pc += 4;
  endtask

  task automatic imm_op(input logic [2:0] f3, input rv32i_pkg::reg_idx_t rd, rs1,
                        input logic [11:0] imm);
    emit_word({imm, rs1, f3, rd, 7'b0010011});
    note_write(rd, alu_ref(f3, f3 == 3'd5 && imm[10], xr[rs1], {{20{imm[11]}}, imm}));
    at_pc += 4;
  endtask

  task automatic load_upper(input rv32i_pkg::reg_idx_t rd, input logic [19:0] imm);
    emit_word({imm, rd, 7'b0110111});
    note_write(rd, {imm, 12'b0});
    at_pc += 4;
  endtask

  task automatic add_upper_pc(input rv32i_pkg::reg_idx_t rd, input logic [19:0] imm);
    emit_word({imm, rd, 7'b0010111});
    note_write(rd, at_pc + {imm, 12'b0});
    at_pc += 4;
  endtask

  task automatic load_const(input rv32i_pkg::reg_idx_t rd, input rv32i_pkg::word_t value);
    rv32i_pkg::word_t upper;
    upper = value + 32'h800;  // addi adds a signed low part
    load_upper(rd, upper[31:12]);
    imm_op(3'd0, rd, rd, value[11:0]);
  endtask

  task automatic jump_link(input rv32i_pkg::reg_idx_t rd, input logic [20:0] offset);
    emit_word({offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111});
    note_write(rd, at_pc + 4);
    at_pc += {{11{offset[20]}}, offset};
  endtask

  task automatic jump_reg(input rv32i_pkg::reg_idx_t rd, rs1, input logic [11:0] imm);
    rv32i_pkg::word_t target;
    target = (xr[rs1] + {{20{imm[11]}}, imm}) & ~32'd1;  // before rd may overwrite rs1
    emit_word({imm, rs1, 3'b000, rd, 7'b1100111});
    note_write(rd, at_pc + 4);
    at_pc = target;
  endtask

  task automatic branch_on(input logic [2:0] f3, input rv32i_pkg::reg_idx_t rs1, rs2,
                           input logic [12:0] offset);
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    logic taken;
    a = xr[rs1];
    b = xr[rs2];
    case (f3)
      3'd0: taken = a == b;
      3'd1: taken = a != b;
      3'd4: taken = $signed(a) < $signed(b);
      3'd5: taken = $signed(a) >= $signed(b);
      3'd6: taken = a < b;
      default: taken = a >= b;
    endcase
    emit_word({offset[12], offset[10:5], rs2, rs1, f3, offset[4:1], offset[11], 7'b1100011});
    at_pc += taken ? {{19{offset[12]}}, offset} : 32'd4;
  endtask

  task automatic store_mem(input logic [1:0] size, input rv32i_pkg::reg_idx_t base, src,
                           input logic [11:0] imm);
    rv32i_pkg::word_t addr;
    int i;
    addr = xr[base] + {{20{imm[11]}}, imm};
    emit_word({imm[11:5], src, base, 1'b0, size, imm[4:0], 7'b0100011});
    for (i = 0; i < (1 << size); i++) begin
      data_bytes[addr + i] = xr[src][8*i +: 8];
    end
    at_pc += 4;
  endtask

  task automatic load_mem(input logic [2:0] f3, input rv32i_pkg::reg_idx_t rd, base,
                          input logic [11:0] imm);
    rv32i_pkg::word_t addr;
    rv32i_pkg::word_t value;
    int i;
    int n;
    addr = xr[base] + {{20{imm[11]}}, imm};
    n = 1 << f3[1:0];
    value = '0;
    for (i = 0; i < n; i++) begin
      value[8*i +: 8] = data_bytes[addr + i];
    end
    if (!f3[2] && value[8*n-1]) begin
      value = value | (~32'd0 << (8 * n));  // sign extend lb and lh
    end
    emit_word({imm, base, f3, rd, 7'b0000011});
    note_write(rd, value);
    at_pc += 4;
  endtask

  task automatic build_program();
    int i;
    logic [11:0] imm;
    for (i = 0; i < RamWords; i++) begin
      prog[i] = rv32i_pkg::word_t'(i) << 8;  // low bits 00 never decode
    end
    for (i = 0; i < 32; i++) begin
      xr[i] = '0;
    end
    expected.delete();
    at_pc = '0;
    prog_len = 0;
    seed = 40644;
    // x1 negative and x2 positive, so signed and unsigned compares differ
    load_const(5'd1, $random(seed) | 32'h8000_0000);
    load_const(5'd2, $random(seed) & 32'h7fff_ffff);
    load_const(5'd3, $random(seed));
    load_const(5'd4, $random(seed) | 32'h0000_8080);
    for (i = 0; i < 8; i++) begin
      reg_op(i[2:0], 1'b0, 5'(5 + i), 5'd1, 5'd2);
    end
    reg_op(3'd0, 1'b1, 5'd13, 5'd1, 5'd2);  // sub
    reg_op(3'd5, 1'b1, 5'd14, 5'd1, 5'd2);  // sra
    reg_op(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);   // add into x0, no retire
    for (i = 0; i < 8; i++) begin
      imm = 12'($random(seed));
      if (i == 1 || i == 5) begin
        imm = {7'b0, imm[4:0]};  // slli, srli
      end
      imm_op(i[2:0], 5'(15 + i), 5'd1, imm);
    end
    imm_op(3'd5, 5'd23, 5'd1, {7'b0100000, 5'($random(seed))});  // srai
    load_upper(5'd24, 20'($random(seed)));
    add_upper_pc(5'd25, 20'($random(seed)));
    jump_link(5'd26, 21'd8);  // skips one fill word
    add_upper_pc(5'd27, 20'd0);
    jump_reg(5'd28, 5'd27, 12'd12);
    imm_op(3'd0, 5'd29, 5'd28, 12'd1);
    for (i = 0; i < 8; i++) begin
      if (i != 2 && i != 3) begin
        branch_on(i[2:0], 5'd1, 5'd2, 13'd8);
        imm_op(3'd0, 5'd30, 5'd0, 12'(i));  // pc shows the branch outcome
        branch_on(i[2:0], 5'd1, 5'd1, 13'd8);
        imm_op(3'd0, 5'd31, 5'd0, 12'(i));
      end
    end
    load_const(5'd9, DataBase);
    store_mem(2'd2, 5'd9, 5'd3, 12'd0);
    store_mem(2'd0, 5'd9, 5'd4, 12'd5);
    store_mem(2'd1, 5'd9, 5'd4, 12'd10);
    load_mem(3'b010, 5'd5, 5'd9, 12'd0);    // lw
    load_mem(3'b000, 5'd6, 5'd9, 12'd5);    // lb
    load_mem(3'b100, 5'd7, 5'd9, 12'd5);    // lbu
    load_mem(3'b001, 5'd8, 5'd9, 12'd10);   // lh
    load_mem(3'b101, 5'd10, 5'd9, 12'd10);  // lhu
    load_mem(3'b001, 5'd11, 5'd9, 12'd2);
    load_mem(3'b100, 5'd12, 5'd9, 12'd3);
    emit_word(32'h0000_0073);  // ecall, unsupported
  endtask

  initial begin
    int i;
    clk = 1'b0;
    rst_n = 1'b0;
    load_valid = 1'b0;
    load = '0;
    start = 1'b0;
    failed = 1'b0;
    built = 1'b0;
    build_program();
    built = 1'b1;
    repeat (ResetCycles) next_cycle();
    rst_n = 1'b1;
    for (i = 0; i < prog_len; i++) begin
      load_valid = 1'b1;
      load = '{address: i, data: prog[i]};
      next_cycle();
    end
    load_valid = 1'b0;
    load = '0;
    repeat (8) begin
      @(negedge clk);
      check_value("retire_valid", retire_valid, 32'd0);  // idle without start
      check_value("fault", fault, 32'd0);
    end
    next_cycle();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    for (i = 0; i < expected.size(); i++) begin
      wait_retire();
      check_value("retire.rd", retire.rd, expected[i].rd);
      check_value("retire.data", retire.data, expected[i].data);
      check_value("retire.pc", retire.pc, expected[i].pc);
    end
    @(negedge clk);
    while (!fault) begin
      if (retire_valid) begin
        report_failure("retire seen after the last expected entry");
      end else begin
        @(negedge clk);
      end
    end
    repeat (20) begin
      @(negedge clk);
      check_value("retire_valid", retire_valid, 32'd0);
      check_value("fault", fault, 32'd1);
    end
    if (!failed) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // hang guard, scaled by program length
  initial begin
    int limit;
    wait (built);
    limit = ResetCycles + prog_len + 10 * prog_len * 4 + 40;
    repeat (limit) @(posedge clk);
    report_failure($sformatf("core did not finish within %0d cycles", limit));
  end

endmodule

// File: project.f
rtl/rv32i_pkg.sv
rtl/ramio_pkg.sv
rtl/decode.sv
rtl/execute.sv
rtl/writeback.sv
rtl/registers.sv
rtl/ramio.sv
rtl/core.sv
rtl/soc_top.sv
bench/soc_assertions.sv
bench/tb_soc.sv
